/* design/axi_mem_array.sv */
`timescale 1ns/1ps

module axi_mem_array #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           mem_we,
    input  logic [$clog2(MEM_WORDS)-1:0]   mem_waddr,
    input  axi_mem_pkg::data_t             mem_wdata,
    input  axi_mem_pkg::strb_t             mem_wstrb,
    input  logic                           mem_re,
    input  logic [$clog2(MEM_WORDS)-1:0]   mem_raddr,
    output axi_mem_pkg::data_t             mem_rdata
);
    import axi_mem_pkg::*;

    localparam int NBYTES = $bits(strb_t);

    data_t mem [MEM_WORDS];
    data_t rdata_q;

    // byte lanes are written only where the strobe is set.
    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (mem_wstrb[b]) begin
                    mem[mem_waddr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // a read of the word being written returns the old contents.
    always_ff @(posedge clk) begin
        if (mem_re) begin
            rdata_q <= mem[mem_raddr];
        end
    end

    assign mem_rdata = rdata_q;

endmodule

/* design/axi_mem_cfg.sv */
`timescale 1ns/1ps

module axi_mem_cfg (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cfg_we,
    input  axi_mem_pkg::cfg_sel_t   cfg_sel,
    input  axi_mem_pkg::addr_t      cfg_wdata,
    output axi_mem_pkg::addr_t      cfg_rdata,
    input  logic                    wr_reject,
    input  logic                    rd_reject,
    output axi_mem_pkg::addr_t      win_base
);
    import axi_mem_pkg::*;

    addr_t               base_q;
    addr_t               cnt_q;
    logic [1:0]          cnt_inc;
    logic [$bits(addr_t):0] cnt_sum;  // one extra bit to catch overflow.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            base_q <= '0;
        end else if (cfg_we && (cfg_sel == CFG_BASE)) begin
            base_q <= cfg_wdata;
        end
    end

    // both paths may reject in the same cycle.
    assign cnt_inc = {1'b0, wr_reject} + {1'b0, rd_reject};
    assign cnt_sum = {1'b0, cnt_q} + {{($bits(addr_t) - 1){1'b0}}, cnt_inc};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (cfg_we && (cfg_sel == CFG_ERRCNT)) begin
            cnt_q <= '0;  // clear wins over a pulse.
        end else if (cnt_sum[$bits(addr_t)]) begin
            cnt_q <= '1;  // saturate.
        end else begin
            cnt_q <= cnt_sum[$bits(addr_t)-1:0];
        end
    end

    assign cfg_rdata = (cfg_sel == CFG_BASE) ? base_q : cnt_q;
    assign win_base  = base_q;

endmodule

/* design/axi_mem_pkg.sv */
package axi_mem_pkg;

    // AXI field widths, sized for a 64-bit data bus.
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [7:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    // response codes.
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // the only request shape the slave serves.
    localparam burst_t BURST_INCR = 2'b01;
    localparam size_t  SIZE_8B    = 3'b011;

    // configuration register select.
    typedef logic cfg_sel_t;

    localparam cfg_sel_t CFG_BASE   = 1'b0;  // window base address.
    localparam cfg_sel_t CFG_ERRCNT = 1'b1;  // rejected-request count.

endpackage

/* design/axi_mem_read.sv */
`timescale 1ns/1ps

module axi_mem_read #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  axi_mem_pkg::id_t               ar_id,
    input  axi_mem_pkg::addr_t             ar_addr,
    input  axi_mem_pkg::len_t              ar_len,
    input  axi_mem_pkg::size_t             ar_size,
    input  axi_mem_pkg::burst_t            ar_burst,
    input  logic                           ar_valid,
    output logic                           ar_ready,
    output axi_mem_pkg::id_t               r_id,
    output axi_mem_pkg::data_t             r_data,
    output axi_mem_pkg::resp_t             r_resp,
    output logic                           r_last,
    output logic                           r_valid,
    input  logic                           r_ready,
    input  axi_mem_pkg::addr_t             win_base,
    output logic                           rd_reject,
    output logic                           mem_re,
    output logic [$clog2(MEM_WORDS)-1:0]   mem_raddr,
    input  axi_mem_pkg::data_t             mem_rdata
);
    import axi_mem_pkg::*;

    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t WIN_BYTES = addr_t'(MEM_WORDS * 8);

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

    rd_state_t state_q;
    rd_state_t state_d;
    logic      first_q;
    logic      ar_hs;
    logic      req_ok;
    addr_t     offset;
    id_t       id_q;
    resp_t     resp_q;

    assign ar_ready = (state_q == RD_IDLE);
    assign ar_hs    = ar_valid && ar_ready;

    assign offset = ar_addr - win_base;
    assign req_ok = (ar_len == '0) && (ar_size == SIZE_8B) && (ar_burst == BURST_INCR)
                    && (offset < WIN_BYTES);

    // the array registers the word, so R follows one cycle after AR.
    assign mem_re    = ar_hs && req_ok;
    assign mem_raddr = offset[IDX_W+2:3];

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (ar_hs) state_d = RD_DATA;
            RD_DATA: if (r_valid && r_ready) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= RD_IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= ar_hs;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            id_q   <= ar_id;
            resp_q <= req_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign r_valid   = (state_q == RD_DATA);
    assign r_last    = r_valid;  // single beat only.
    assign r_id      = id_q;
    assign r_resp    = resp_q;
    assign r_data    = (resp_q == RESP_OKAY) ? mem_rdata : '0;
    assign rd_reject = first_q && (resp_q != RESP_OKAY);

endmodule

/* design/axi_mem_top.sv */
`timescale 1ns/1ps

module axi_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  axi_mem_pkg::id_t        aw_id,
    input  axi_mem_pkg::addr_t      aw_addr,
    input  axi_mem_pkg::len_t       aw_len,
    input  axi_mem_pkg::size_t      aw_size,
    input  axi_mem_pkg::burst_t     aw_burst,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_mem_pkg::data_t      w_data,
    input  axi_mem_pkg::strb_t      w_strb,
    input  logic                    w_last,
    input  logic                    w_valid,
    output logic                    w_ready,
    output axi_mem_pkg::id_t        b_id,
    output axi_mem_pkg::resp_t      b_resp,
    output logic                    b_valid,
    input  logic                    b_ready,
    input  axi_mem_pkg::id_t        ar_id,
    input  axi_mem_pkg::addr_t      ar_addr,
    input  axi_mem_pkg::len_t       ar_len,
    input  axi_mem_pkg::size_t      ar_size,
    input  axi_mem_pkg::burst_t     ar_burst,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axi_mem_pkg::id_t        r_id,
    output axi_mem_pkg::data_t      r_data,
    output axi_mem_pkg::resp_t      r_resp,
    output logic                    r_last,
    output logic                    r_valid,
    input  logic                    r_ready,
    input  logic                    cfg_we,
    input  axi_mem_pkg::cfg_sel_t   cfg_sel,
    input  axi_mem_pkg::addr_t      cfg_wdata,
    output axi_mem_pkg::addr_t      cfg_rdata
);
    import axi_mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    addr_t            win_base;
    logic             wr_reject;
    logic             rd_reject;
    logic             mem_we;
    logic [IDX_W-1:0] mem_waddr;
    data_t            mem_wdata;
    strb_t            mem_wstrb;
    logic             mem_re;
    logic [IDX_W-1:0] mem_raddr;
    data_t            mem_rdata;

    axi_mem_write #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_write (
        .clk, .arst_n,
        .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_last, .w_valid, .w_ready,
        .b_id, .b_resp, .b_valid, .b_ready,
        .win_base, .wr_reject,
        .mem_we, .mem_waddr, .mem_wdata, .mem_wstrb
    );

    axi_mem_read #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_read (
        .clk, .arst_n,
        .ar_id, .ar_addr, .ar_len, .ar_size, .ar_burst, .ar_valid, .ar_ready,
        .r_id, .r_data, .r_resp, .r_last, .r_valid, .r_ready,
        .win_base, .rd_reject,
        .mem_re, .mem_raddr, .mem_rdata
    );

    axi_mem_array #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_array (
        .clk,
        .mem_we, .mem_waddr, .mem_wdata, .mem_wstrb,
        .mem_re, .mem_raddr, .mem_rdata
    );

    // window base and reject counter, shared by both paths.
    axi_mem_cfg i_axi_mem_cfg (
        .clk, .arst_n,
        .cfg_we, .cfg_sel, .cfg_wdata, .cfg_rdata,
        .wr_reject, .rd_reject,
        .win_base
    );

endmodule

/* design/axi_mem_write.sv */
`timescale 1ns/1ps

module axi_mem_write #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  axi_mem_pkg::id_t               aw_id,
    input  axi_mem_pkg::addr_t             aw_addr,
    input  axi_mem_pkg::len_t              aw_len,
    input  axi_mem_pkg::size_t             aw_size,
    input  axi_mem_pkg::burst_t            aw_burst,
    input  logic                           aw_valid,
    output logic                           aw_ready,
    input  axi_mem_pkg::data_t             w_data,
    input  axi_mem_pkg::strb_t             w_strb,
    input  logic                           w_last,
    input  logic                           w_valid,
    output logic                           w_ready,
    output axi_mem_pkg::id_t               b_id,
    output axi_mem_pkg::resp_t             b_resp,
    output logic                           b_valid,
    input  logic                           b_ready,
    input  axi_mem_pkg::addr_t             win_base,
    output logic                           wr_reject,
    output logic                           mem_we,
    output logic [$clog2(MEM_WORDS)-1:0]   mem_waddr,
    output axi_mem_pkg::data_t             mem_wdata,
    output axi_mem_pkg::strb_t             mem_wstrb
);
    import axi_mem_pkg::*;

    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t WIN_BYTES = addr_t'(MEM_WORDS * 8);

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    wr_state_t        state_q;
    wr_state_t        state_d;
    logic             first_q;     // first cycle of WR_RESP.
    logic             wr_hs;
    logic             req_ok;
    addr_t            offset;
    id_t              id_q;
    resp_t            resp_q;
    logic [IDX_W-1:0] idx_q;
    data_t            data_q;
    strb_t            strb_q;

    // AW and W are only granted together.
    assign aw_ready = (state_q == WR_IDLE) && aw_valid && w_valid;
    assign w_ready  = aw_ready;
    assign wr_hs    = aw_valid && aw_ready;

    assign offset = aw_addr - win_base;
    assign req_ok = (aw_len == '0) && (aw_size == SIZE_8B) && (aw_burst == BURST_INCR)
                    && w_last && (offset < WIN_BYTES);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (wr_hs) state_d = WR_RESP;
            WR_RESP: if (b_valid && b_ready) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= WR_IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= wr_hs;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            id_q   <= aw_id;
            idx_q  <= offset[IDX_W+2:3];  // byte offset to word index.
            data_q <= w_data;
            strb_q <= w_strb;
            resp_q <= req_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign b_valid = (state_q == WR_RESP);
    assign b_id    = id_q;
    assign b_resp  = resp_q;

    // one memory write, or one reject pulse, per accepted request.
    assign mem_we    = first_q && (resp_q == RESP_OKAY);
    assign wr_reject = first_q && (resp_q != RESP_OKAY);
    assign mem_waddr = idx_q;
    assign mem_wdata = data_q;
    assign mem_wstrb = strb_q;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module axi_mem_tb -f vlog.f -o axi_mem_sim

if ./obj_dir/axi_mem_sim | tee /dev/stderr | grep -qx "ALL TESTS PASSED"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/axi_mem_assert.sv */
`timescale 1ns/1ps

module axi_mem_assert (
    input logic                clk,
    input logic                arst_n,
    input logic                aw_ready,
    input logic                w_ready,
    input logic                ar_ready,
    input axi_mem_pkg::id_t    b_id,
    input axi_mem_pkg::resp_t  b_resp,
    input logic                b_valid,
    input logic                b_ready,
    input axi_mem_pkg::id_t    r_id,
    input axi_mem_pkg::data_t  r_data,
    input axi_mem_pkg::resp_t  r_resp,
    input logic                r_valid,
    input logic                r_ready
);

    // a response stays up, payload steady, until the manager takes it.
    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
        else $error("B response dropped or changed before b_ready");

    r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_id) && $stable(r_data) && $stable(r_resp))
        else $error("R response dropped or changed before r_ready");

    aw_w_ready: assert property (@(posedge clk) disable iff (!arst_n) aw_ready == w_ready)
        else $error("aw_ready and w_ready differ");

    ar_blocked: assert property (@(posedge clk) disable iff (!arst_n) r_valid |-> !ar_ready)
        else $error("ar_ready high while R is pending");  // one read in flight.

endmodule

bind axi_mem_top axi_mem_assert i_axi_mem_assert (
    .clk, .arst_n, .aw_ready, .w_ready, .ar_ready,
    .b_id, .b_resp, .b_valid, .b_ready,
    .r_id, .r_data, .r_resp, .r_valid, .r_ready
);

/* sim/axi_mem_tb.sv */
`timescale 1ns/1ps

module axi_mem_tb;
    import axi_mem_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int N_RAND    = 40;
    localparam int N_PART    = 20;
    localparam int N_TRANS   = 2 * N_RAND + 2 * N_PART + 11;  // 11 reject and relocation transfers.
    localparam int LIMIT     = 40 * N_TRANS + 100;

    logic     clk, arst_n;
    id_t      aw_id, b_id, ar_id, r_id;
    addr_t    aw_addr, ar_addr, cfg_wdata, cfg_rdata;
    len_t     aw_len, ar_len;
    size_t    aw_size, ar_size;
    burst_t   aw_burst, ar_burst;
    data_t    w_data, r_data;
    strb_t    w_strb;
    resp_t    b_resp, r_resp;
    cfg_sel_t cfg_sel;
    logic     aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic     ar_valid, ar_ready, r_last, r_valid, r_ready, cfg_we;

    data_t  model_mem [int];  // reference words, keyed by word index.
    int     written [$];
    addr_t  model_base;
    addr_t  model_errcnt;
    integer seed = 32'h3cc6_d1c9;
    int     cycles = 0;

    axi_mem_top #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic addr_t word_addr(input int idx);
        return model_base + addr_t'(idx * 8);
    endfunction

    function automatic int pick_written();
        return written[rand_below(written.size())];
    endfunction

    // strobed bytes take the new value, the rest keep the old one.
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t res;
        res = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic axi_write(input string name, input addr_t addr, input len_t len,
                             input size_t size, input data_t data, input strb_t strb,
                             input resp_t exp_resp);
        id_t id;
        id = id_t'($random(seed));
        @(negedge clk);
        aw_id    = id;
        aw_addr  = addr;
        aw_len   = len;
        aw_size  = size;
        w_data   = data;
        w_strb   = strb;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        wait (aw_ready && w_ready);  // both granted while both valids are high.
        @(negedge clk);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        check_bit({name, " b_valid one cycle after AW and W"}, 1'b1, b_valid);
        repeat (rand_below(4)) @(negedge clk);
        check_id({name, " b_id"}, id, b_id);
        check_resp({name, " b_resp"}, exp_resp, b_resp);
        b_ready = 1'b1;
        @(negedge clk);
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input string name, input addr_t addr, input len_t len,
                            input size_t size, input data_t exp_data, input resp_t exp_resp);
        id_t id;
        id = id_t'($random(seed));
        @(negedge clk);
        ar_id    = id;
        ar_addr  = addr;
        ar_len   = len;
        ar_size  = size;
        ar_valid = 1'b1;
        while (!ar_ready) @(negedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
        check_bit({name, " r_valid one cycle after AR"}, 1'b1, r_valid);
        repeat (rand_below(4)) @(negedge clk);
        check_id({name, " r_id"}, id, r_id);
        check_resp({name, " r_resp"}, exp_resp, r_resp);
        check_data({name, " r_data"}, exp_data, r_data);
        check_bit({name, " r_last"}, 1'b1, r_last);
        r_ready = 1'b1;
        @(negedge clk);
        r_ready = 1'b0;
    endtask

    task automatic write_ok(input string name, input int idx, input data_t data, input strb_t strb);
        data_t old;
        old = model_mem.exists(idx) ? model_mem[idx] : '0;
        axi_write(name, word_addr(idx), '0, SIZE_8B, data, strb, RESP_OKAY);
        if (!model_mem.exists(idx)) begin
            written.push_back(idx);
        end
        model_mem[idx] = merge_bytes(old, data, strb);
    endtask

    task automatic cfg_write(input cfg_sel_t sel, input addr_t value);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = value;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic cfg_expect(input string name, input cfg_sel_t sel, input addr_t exp);
        @(negedge clk);
        cfg_sel = sel;
        @(negedge clk);
        check_cfg(name, exp, cfg_rdata);
    endtask

    initial begin
        int    idx;
        addr_t old_base;
        arst_n       = 1'b0;
        {aw_id, aw_addr, aw_len, w_data, w_strb} = '0;
        {ar_id, ar_addr, ar_len, cfg_wdata} = '0;
        aw_size      = SIZE_8B;
        ar_size      = SIZE_8B;
        aw_burst     = BURST_INCR;
        ar_burst     = BURST_INCR;
        w_last       = 1'b1;
        {aw_valid, w_valid, b_ready, ar_valid, r_ready, cfg_we} = '0;
        cfg_sel      = CFG_BASE;
        model_base   = '0;
        model_errcnt = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_bit("reset b_valid", 1'b0, b_valid);
        check_bit("reset r_valid", 1'b0, r_valid);
        check_bit("reset aw_ready", 1'b0, aw_ready);
        check_bit("reset w_ready", 1'b0, w_ready);
        check_bit("reset ar_ready", 1'b1, ar_ready);
        cfg_expect("reset base", CFG_BASE, '0);
        cfg_expect("reset errcnt", CFG_ERRCNT, '0);

        for (int i = 0; i < N_RAND; i++) begin
            write_ok("random write", rand_below(MEM_WORDS), rand_data(), 8'hff);
            idx = pick_written();
            axi_read("random read", word_addr(idx), '0, SIZE_8B, model_mem[idx], RESP_OKAY);
        end

        for (int i = 0; i < N_PART; i++) begin
            idx = pick_written();
            write_ok("strobe write", idx, rand_data(), strb_t'($random(seed)));
            axi_read("strobe read", word_addr(idx), '0, SIZE_8B, model_mem[idx], RESP_OKAY);
        end

        // the out-of-window address would alias onto the same word.
        idx = pick_written();
        axi_write("bad len write", word_addr(idx), 8'd1, SIZE_8B, rand_data(), 8'hff, RESP_SLVERR);
        axi_write("bad size write", word_addr(idx), '0, 3'd2, rand_data(), 8'hff, RESP_SLVERR);
        axi_write("range write", word_addr(idx + MEM_WORDS), '0, SIZE_8B, rand_data(), 8'hff,
                  RESP_SLVERR);
        axi_read("unchanged read", word_addr(idx), '0, SIZE_8B, model_mem[idx], RESP_OKAY);
        axi_read("bad len read", word_addr(idx), 8'd1, SIZE_8B, '0, RESP_SLVERR);
        axi_read("bad size read", word_addr(idx), '0, 3'd2, '0, RESP_SLVERR);
        axi_read("range read", word_addr(idx + MEM_WORDS), '0, SIZE_8B, '0, RESP_SLVERR);
        model_errcnt = model_errcnt + 6;
        cfg_expect("reject count", CFG_ERRCNT, model_errcnt);

        old_base   = model_base;
        model_base = 32'h0001_0000;
        cfg_write(CFG_BASE, model_base);
        cfg_expect("new base", CFG_BASE, model_base);
        idx = pick_written();
        axi_write("old window write", old_base + addr_t'(idx * 8), '0, SIZE_8B, rand_data(),
                  8'hff, RESP_SLVERR);
        write_ok("new window write", idx, rand_data(), 8'hff);
        axi_read("new window read", word_addr(idx), '0, SIZE_8B, model_mem[idx], RESP_OKAY);
        axi_read("old window read", old_base + addr_t'(idx * 8), '0, SIZE_8B, '0, RESP_SLVERR);
        model_errcnt = model_errcnt + 2;
        cfg_expect("relocated count", CFG_ERRCNT, model_errcnt);
        cfg_write(CFG_ERRCNT, '0);
        model_errcnt = '0;
        cfg_expect("cleared count", CFG_ERRCNT, model_errcnt);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
design/axi_mem_pkg.sv
design/axi_mem_array.sv
design/axi_mem_cfg.sv
design/axi_mem_write.sv
design/axi_mem_read.sv
design/axi_mem_top.sv
sim/axi_mem_assert.sv
sim/axi_mem_tb.sv
